/* spi_resp_pkg.sv */
////////////////////////////////////////////////////////////
// sizes, localparams and packed payload structs shared by the
// SPI response path RTL and its testbench, used by scoped names
////////////////////////////////////////////////////////////

package spi_resp_pkg;

  // number of independent response sources and the width of a source number
  localparam int num_sources = 3;
  localparam int src_bits = $clog2(num_sources);

  // a full response is cut into narrow chunks for the SPI side
  localparam int resp_bits = 32;
  localparam int chunk_bits = 8;
  localparam int chunks_per_resp = resp_bits / chunk_bits;
  localparam int chunk_count_bits = $clog2(chunks_per_resp);

  // every msg_queue in the path holds this many entries
  localparam int queue_depth = 2;
  localparam int queue_count_bits = $clog2(queue_depth + 1);

  typedef logic [src_bits-1:0] src_t;
  typedef logic [chunk_count_bits-1:0] chunk_count_t;
  typedef logic [queue_count_bits-1:0] queue_count_t;

  // counter values the RTL compares against
  localparam chunk_count_t last_chunk = chunk_count_t'(chunks_per_resp - 1);
  localparam queue_count_t queue_full = queue_count_t'(queue_depth);

  // one complete response as delivered by a source
  typedef struct packed {
    logic [resp_bits-1:0] data;
  } response_t;

  // one chunk leaving a disassembler, last marks the final chunk of a response
  typedef struct packed {
    logic                  last;
    logic [chunk_bits-1:0] data;
  } chunk_t;

  // a framed chunk as the SPI wrapper sees it, tagged with its source number
  typedef struct packed {
    src_t                  src;
    logic                  last;
    logic [chunk_bits-1:0] data;
  } spi_flit_t;

endpackage

/* msg_queue.sv */
////////////////////////////////////////////////////////////
// two-entry val/rdy queue with registered outputs, the payload
// type is a parameter so one queue serves responses and flits
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module msg_queue #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,

  input  logic     enq_val,
  output logic     enq_rdy,
  input  payload_t enq_msg,

  output logic     deq_val,
  input  logic     deq_rdy,
  output payload_t deq_msg
);

  // head is what the consumer sees, tail only holds the second entry
  payload_t                   head_msg;
  payload_t                   tail_msg;
  spi_resp_pkg::queue_count_t count;

  logic do_enq;
  logic do_deq;

  // enq_rdy looks only at the registered count, so there is no
  // combinational path from deq_rdy back to the producer
  assign enq_rdy = (count < spi_resp_pkg::queue_full);
  assign deq_val = (count != '0);
  assign deq_msg = head_msg;

  assign do_enq = enq_val & enq_rdy;
  assign do_deq = deq_val & deq_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage carries no reset, the count alone says which entries are live
  always_ff @(posedge clk) begin
    // a push lands in head when the queue is empty or the head is leaving
    if (do_enq && ((count == '0) ||
        ((count == spi_resp_pkg::queue_count_t'(1)) && do_deq))) begin
      head_msg <= enq_msg;
    end else if (do_deq && (count == spi_resp_pkg::queue_full)) begin
      // full queue popping, the second entry moves up
      head_msg <= tail_msg;
    end

    // with one entry held and no pop the new entry waits behind it
    if (do_enq && (count == spi_resp_pkg::queue_count_t'(1)) && !do_deq) begin
      tail_msg <= enq_msg;
    end
  end

endmodule

/* packet_disassembler.sv */
////////////////////////////////////////////////////////////
// cuts one queued response into chunks for the narrow SPI side,
// most significant byte first, with last on the final chunk
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module packet_disassembler (
  input  logic                     clk,
  input  logic                     reset,

  // queued response from the source queue
  input  logic                     resp_val,
  output logic                     resp_rdy,
  input  spi_resp_pkg::response_t  resp_msg,

  // chunk stream towards the arbiter
  output logic                     chunk_val,
  input  logic                     chunk_rdy,
  output spi_resp_pkg::chunk_t     chunk_msg
);

  // response being sent, the next chunk always sits in the top bits
  logic [spi_resp_pkg::resp_bits-1:0] shift_reg;

  // number of chunks already sent from the current response
  spi_resp_pkg::chunk_count_t count;

  // high from the load until the last chunk has transferred
  logic busy;

  logic load;
  logic xfer;
  logic is_last;

  // a new response is only taken while idle, so after the final chunk
  // there is always one cycle with chunk_val low before the next one
  assign resp_rdy = !busy;
  assign load = resp_val & resp_rdy;

  // the arbiter keeps its grant as long as this stays high, so val
  // must not drop between the chunks of one response
  assign chunk_val = busy;
  assign xfer = chunk_val & chunk_rdy;

  assign is_last = (count == spi_resp_pkg::last_chunk);

  assign chunk_msg.last = is_last;
  assign chunk_msg.data = shift_reg[spi_resp_pkg::resp_bits-1 -: spi_resp_pkg::chunk_bits];

  // control state
  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (load) begin
      busy  <= 1'b1;
      count <= '0;
    end else if (xfer) begin
      count <= count + 1'b1;
      // final chunk accepted, go idle for the one-cycle gap
      if (is_last) begin
        busy <= 1'b0;
      end
    end
  end

  // payload register, only meaningful while busy
  always_ff @(posedge clk) begin
    if (load) begin
      shift_reg <= resp_msg.data;
    end else if (xfer) begin
      // move the next byte up into the output position
      shift_reg <= {
        shift_reg[spi_resp_pkg::resp_bits-spi_resp_pkg::chunk_bits-1:0],
        {spi_resp_pkg::chunk_bits{1'b0}}
      };
    end
  end

endmodule

/* response_arbiter.sv */
////////////////////////////////////////////////////////////
// picks one disassembler at a time for the SPI output and tags
// each chunk with its source number, grant is held per packet
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module response_arbiter (
  input  logic                      clk,
  input  logic                      reset,

  // one chunk stream per source
  input  logic                      chunk_val [spi_resp_pkg::num_sources],
  output logic                      chunk_rdy [spi_resp_pkg::num_sources],
  input  spi_resp_pkg::chunk_t      chunk_msg [spi_resp_pkg::num_sources],

  // framed chunks towards the output queue
  output logic                      flit_val,
  input  logic                      flit_rdy,
  output spi_resp_pkg::spi_flit_t   flit_msg
);

  // source that owns the output this cycle
  spi_resp_pkg::src_t grant;

  // grant of the previous cycle, used to keep a packet together
  spi_resp_pkg::src_t prev_grant;

  // lowest numbered source with val high, or source 0 when none is valid
  spi_resp_pkg::src_t encoder_out;

  // priority encoder
  // walking from the highest index down lets the lowest valid index win
  always_comb begin
    encoder_out = '0;
    for (int i = spi_resp_pkg::num_sources - 1; i >= 0; i--) begin
      if (chunk_val[i]) begin
        encoder_out = spi_resp_pkg::src_t'(i);
      end
    end
  end

  // a disassembler keeps val high across all chunks of a response and
  // drops it for one cycle afterwards, so a low val on the previous
  // owner marks a packet boundary where the grant may move
  always_comb begin
    if (chunk_val[prev_grant]) begin
      grant = prev_grant;
    end else begin
      grant = encoder_out;
    end
  end

  // only the granted source may see the downstream ready
  always_comb begin
    for (int i = 0; i < spi_resp_pkg::num_sources; i++) begin
      if (grant == spi_resp_pkg::src_t'(i)) begin
        chunk_rdy[i] = flit_rdy;
      end else begin
        chunk_rdy[i] = 1'b0;
      end
    end
  end

  // val is gated by ready, so a stalled output queue sees nothing at all
  assign flit_val = chunk_val[grant] & chunk_rdy[grant];

  // prefix the granted chunk with its source number
  assign flit_msg.src  = grant;
  assign flit_msg.last = chunk_msg[grant].last;
  assign flit_msg.data = chunk_msg[grant].data;

  // trailing copy of the grant, updated on every edge whether or not
  // a chunk moved, so a stalled packet keeps its owner
  always_ff @(posedge clk) begin
    if (reset) begin
      prev_grant <= '0;
    end else begin
      prev_grant <= grant;
    end
  end

endmodule

/* spi_response_path.sv */
////////////////////////////////////////////////////////////
// response return path top, per-source queues and disassemblers
// merged by the arbiter into one registered SPI-side flit stream
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module spi_response_path (
  input  logic                      clk,
  input  logic                      reset,

  // one response stream per source
  input  logic                      resp_val [spi_resp_pkg::num_sources],
  output logic                      resp_rdy [spi_resp_pkg::num_sources],
  input  spi_resp_pkg::response_t   resp_msg [spi_resp_pkg::num_sources],

  // framed chunks for the SPI wrapper
  output logic                      spi_val,
  input  logic                      spi_rdy,
  output spi_resp_pkg::spi_flit_t   spi_msg
);

  // source queue outputs into the disassemblers
  logic                      q_val [spi_resp_pkg::num_sources];
  logic                      q_rdy [spi_resp_pkg::num_sources];
  spi_resp_pkg::response_t   q_msg [spi_resp_pkg::num_sources];

  // disassembler chunks into the arbiter
  logic                      chunk_val [spi_resp_pkg::num_sources];
  logic                      chunk_rdy [spi_resp_pkg::num_sources];
  spi_resp_pkg::chunk_t      chunk_msg [spi_resp_pkg::num_sources];

  // arbiter output into the output queue
  logic                      flit_val;
  logic                      flit_rdy;
  spi_resp_pkg::spi_flit_t   flit_msg;

  // each source gets its own queue and disassembler
  for (genvar i = 0; i < spi_resp_pkg::num_sources; i++) begin : g_source
    msg_queue #(
      .payload_t (spi_resp_pkg::response_t)
    ) u_resp_queue (
      .clk     (clk),
      .reset   (reset),
      .enq_val (resp_val[i]),
      .enq_rdy (resp_rdy[i]),
      .enq_msg (resp_msg[i]),
      .deq_val (q_val[i]),
      .deq_rdy (q_rdy[i]),
      .deq_msg (q_msg[i])
    );

    packet_disassembler u_disasm (
      .clk       (clk),
      .reset     (reset),
      .resp_val  (q_val[i]),
      .resp_rdy  (q_rdy[i]),
      .resp_msg  (q_msg[i]),
      .chunk_val (chunk_val[i]),
      .chunk_rdy (chunk_rdy[i]),
      .chunk_msg (chunk_msg[i])
    );
  end

  response_arbiter u_arbiter (
    .clk       (clk),
    .reset     (reset),
    .chunk_val (chunk_val),
    .chunk_rdy (chunk_rdy),
    .chunk_msg (chunk_msg),
    .flit_val  (flit_val),
    .flit_rdy  (flit_rdy),
    .flit_msg  (flit_msg)
  );

  // registers the SPI side and cuts the ready path back into the arbiter
  msg_queue #(
    .payload_t (spi_resp_pkg::spi_flit_t)
  ) u_spi_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (flit_val),
    .enq_rdy (flit_rdy),
    .enq_msg (flit_msg),
    .deq_val (spi_val),
    .deq_rdy (spi_rdy),
    .deq_msg (spi_msg)
  );

endmodule

/* tb_spi_response_path.sv */
////////////////////////////////////////////////////////////
// testbench for the SPI response path, feeds the three sources
// and checks every framed flit against per-source scoreboards
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_spi_response_path;

  // the random test needs about 1000 cycles, the limit is four times that
  localparam int cycle_limit = 4000;
  localparam int num_random = 200;
  localparam int burst_len = 5;
  localparam int pattern_len = 1024;

  logic                    clk;
  logic                    reset;
  logic                    resp_val [spi_resp_pkg::num_sources];
  logic                    resp_rdy [spi_resp_pkg::num_sources];
  spi_resp_pkg::response_t resp_msg [spi_resp_pkg::num_sources];
  logic                    spi_val;
  logic                    spi_rdy;
  spi_resp_pkg::spi_flit_t spi_msg;

  // responses accepted by the DUT and not yet seen at the SPI side
  logic [spi_resp_pkg::resp_bits-1:0] expected_q [spi_resp_pkg::num_sources][$];
  // source number of every completed packet in arrival order
  int order_q [$];

  // packet being rebuilt from the flit stream
  int                                 pkt_count;
  spi_resp_pkg::src_t                 pkt_src;
  logic [spi_resp_pkg::resp_bits-1:0] pkt_data;
  int                                 packets_done;
  int                                 flits_seen;

  // flit that was offered while spi_rdy was low, it must stay put
  logic                    held_valid;
  spi_resp_pkg::spi_flit_t held_flit;

  int     errors;
  int     tests_passed;
  int     tests_failed;
  int     test_errors_start;
  string  test_name;
  int     cycle_count = 0;
  integer seed;

  spi_response_path dut (
    .clk      (clk),
    .reset    (reset),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg),
    .spi_val  (spi_val),
    .spi_rdy  (spi_rdy),
    .spi_msg  (spi_msg)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // runaway guard, ends the run if a test never finishes
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: %0d cycles passed and the tests did not finish", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic mismatch_error(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("FAIL at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic protocol_error(input string what);
    $display("error at %0t ns: %s", $time, what);
    errors++;
  endtask

  // rebuilds packets, most significant chunk first, and scores them
  task automatic check_flit(input spi_resp_pkg::spi_flit_t flit);
    int          src;
    logic [31:0] want;
    src = int'(flit.src);
    flits_seen++;
    // once a packet has started its source owns the output until last
    if (pkt_count != 0) begin
      assert (flit.src == pkt_src)
        else mismatch_error("spi_msg.src", 32'(pkt_src), 32'(flit.src));
    end
    assert (flit.last == (pkt_count == spi_resp_pkg::chunks_per_resp - 1))
      else mismatch_error("spi_msg.last",
                          32'(pkt_count == spi_resp_pkg::chunks_per_resp - 1), 32'(flit.last));
    pkt_src = flit.src;
    pkt_data = {pkt_data[spi_resp_pkg::resp_bits-spi_resp_pkg::chunk_bits-1:0], flit.data};
    if (pkt_count == spi_resp_pkg::chunks_per_resp - 1) begin
      pkt_count = 0;
      packets_done++;
      order_q.push_back(src);
      assert (src < spi_resp_pkg::num_sources)
        else protocol_error("a packet carries a source number that does not exist");
      if (src < spi_resp_pkg::num_sources) begin
        assert (expected_q[src].size() > 0)
          else protocol_error($sformatf("source %0d sent a packet nobody queued", src));
        if (expected_q[src].size() > 0) begin
          want = expected_q[src].pop_front();
          assert (pkt_data == want)
            else mismatch_error($sformatf("response data of source %0d", src), want, pkt_data);
        end
      end
    end else begin
      pkt_count++;
    end
  endtask

  // monitor, samples at the falling edge where every signal is settled
  always @(negedge clk) begin
    if (reset) begin
      pkt_count = 0;
      held_valid = 1'b0;
    end else begin
      for (int s = 0; s < spi_resp_pkg::num_sources; s++) begin
        if (resp_val[s] && resp_rdy[s]) begin
          expected_q[s].push_back(resp_msg[s].data);
        end
      end
      if (held_valid) begin
        assert (spi_val) else protocol_error("spi_val fell while a flit waited for spi_rdy");
        assert (spi_msg == held_flit)
          else mismatch_error("spi_msg", 32'(held_flit), 32'(spi_msg));
      end
      held_valid = spi_val && !spi_rdy;
      held_flit = spi_msg;
      if (spi_val && spi_rdy) begin
        check_flit(spi_msg);
      end
    end
  end

  function automatic int outstanding();
    int total;
    total = 0;
    for (int s = 0; s < spi_resp_pkg::num_sources; s++) begin
      total += expected_q[s].size();
    end
    return total;
  endfunction

  // offers one response and holds it until the source queue takes it
  task automatic send_response(input int src, input logic [31:0] data);
    @(posedge clk);
    resp_val[src] <= 1'b1;
    resp_msg[src].data <= data;
    @(negedge clk);
    while (!resp_rdy[src]) @(negedge clk);
    @(posedge clk);
    resp_val[src] <= 1'b0;
  endtask

  // one response on every source in the same cycle
  task automatic send_all_sources();
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] d2;
    d0 = $random(seed);
    d1 = $random(seed);
    d2 = $random(seed);
    fork
      send_response(0, d0);
      send_response(1, d1);
      send_response(2, d2);
    join
  endtask

  // waits until every accepted response came out, then checks idle
  task automatic wait_drain();
    @(posedge clk);
    while (outstanding() != 0 || pkt_count != 0) @(posedge clk);
    repeat (3) @(negedge clk);
    assert (!spi_val) else protocol_error("spi_val stayed high with nothing outstanding");
  endtask

  task automatic check_idle_outputs();
    assert (!spi_val) else mismatch_error("spi_val", 32'd0, 32'(spi_val));
    for (int s = 0; s < spi_resp_pkg::num_sources; s++) begin
      assert (resp_rdy[s]) else mismatch_error($sformatf("resp_rdy[%0d]", s), 32'd1, 32'd0);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    assert (actual == expected) else mismatch_error(name, expected, actual);
  endtask

  task automatic open_test(input string name);
    test_name = name;
    test_errors_start = errors;
  endtask

  task automatic close_test();
    if (errors == test_errors_start) begin
      tests_passed++;
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_errors_start);
    end
  endtask

  initial begin
    int          base;
    int          flits_base;
    int          step;
    logic        sends_done;
    logic        stall_seen;
    logic [31:0] r;
    int          rand_src [num_random];
    logic [31:0] rand_data [num_random];
    logic        rdy_pattern [pattern_len];
    seed = 32'hd1d3;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    packets_done = 0;
    flits_seen = 0;
    pkt_count = 0;
    held_valid = 1'b0;
    reset = 1'b1;
    spi_rdy = 1'b0;
    for (int s = 0; s < spi_resp_pkg::num_sources; s++) begin
      resp_val[s] = 1'b0;
      resp_msg[s] = '0;
    end

    // reset holds for two rising edges, outputs are checked on both sides
    open_test("reset state and single response");
    @(posedge clk);
    @(negedge clk);
    check_idle_outputs();
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle_outputs();
    @(posedge clk);
    spi_rdy <= 1'b1;
    base = packets_done;
    flits_base = flits_seen;
    r = $random(seed);
    send_response(1, r);
    wait_drain();
    check_count("flits from one response", 4, flits_seen - flits_base);
    check_count("packets received", 1, packets_done - base);
    check_count("spi_msg.src of the packet", 1, order_q[$]);
    close_test();

    // all sources at once, the flit monitor checks that packets never mix
    open_test("packet atomicity");
    base = packets_done;
    repeat (3) send_all_sources();
    wait_drain();
    check_count("packets received", 9, packets_done - base);
    close_test();

    // loaded together under back-pressure, released in priority order
    open_test("fixed priority");
    @(posedge clk);
    spi_rdy <= 1'b0;
    base = order_q.size();
    send_all_sources();
    repeat (10) @(posedge clk);
    spi_rdy <= 1'b1;
    wait_drain();
    check_count("packets received", 3, order_q.size() - base);
    if (order_q.size() == base + 3) begin
      for (int i = 0; i < 3; i++) begin
        check_count($sformatf("spi_msg.src of packet %0d", i), i, order_q[base + i]);
      end
    end
    close_test();

    // random sources and data with spi_rdy high about three cycles in four
    open_test("back-pressure and integrity");
    for (int i = 0; i < num_random; i++) begin
      r = $random(seed);
      rand_src[i] = int'(r[15:0]) % spi_resp_pkg::num_sources;
      rand_data[i] = $random(seed);
    end
    for (int i = 0; i < pattern_len; i++) begin
      r = $random(seed);
      rdy_pattern[i] = (r[1:0] != 2'b00);
    end
    base = packets_done;
    sends_done = 1'b0;
    step = 0;
    fork
      begin
        for (int i = 0; i < num_random; i++) begin
          send_response(rand_src[i], rand_data[i]);
        end
        sends_done = 1'b1;
      end
      begin
        while (!sends_done) begin
          @(posedge clk);
          spi_rdy <= rdy_pattern[step % pattern_len];
          step++;
        end
      end
    join
    @(posedge clk);
    spi_rdy <= 1'b1;
    wait_drain();
    check_count("packets received", num_random, packets_done - base);
    close_test();

    // a burst deeper than the buffering must stall source 2
    open_test("source stall");
    @(posedge clk);
    spi_rdy <= 1'b0;
    base = packets_done;
    stall_seen = 1'b0;
    fork
      begin
        for (int i = 0; i < burst_len; i++) begin
          r = $random(seed);
          send_response(2, r);
        end
      end
      begin
        for (int c = 0; c < 40 && !stall_seen; c++) begin
          @(negedge clk);
          if (!resp_rdy[2]) stall_seen = 1'b1;
        end
        assert (stall_seen)
          else protocol_error("resp_rdy of source 2 never fell under back-pressure");
        repeat (8) @(posedge clk);
        spi_rdy <= 1'b1;
      end
    join
    wait_drain();
    check_count("packets received", burst_len, packets_done - base);
    close_test();

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
spi_resp_pkg.sv
msg_queue.sv
packet_disassembler.sv
response_arbiter.sv
spi_response_path.sv
tb_spi_response_path.sv

/* run_sim.sh */
#!/bin/sh
# builds the SPI response path testbench with Verilator and runs it,
# the exit status is non-zero when the log reports a failure

set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log
top=tb_spi_response_path

# --binary builds a standalone executable, --assert keeps the checks live
verilator --binary --assert --timing \
  --top-module "$top" \
  --Mdir "$build_dir" \
  -f filelist.f

"./$build_dir/V$top" | tee "$log_file"

if grep -q "Simulation failed" "$log_file"; then
  echo "simulation reported a failure, see $log_file"
  exit 1
fi

echo "simulation log is in $log_file"
